// ==== Bender.yml ====
package:
  name: kcpu_regs

sources:
  # packages first, then the RTL
  - src/kcpu_arch_pkg.sv
  - src/kcpu_ctrl_pkg.sv
  - src/kcpu_xfer_cnt.sv
  - src/kcpu_stack_seq.sv
  - src/kcpu_regs.sv
  - src/kcpu_regs_top.sv
  - target: test
    files:
      - tests/kcpu_stack_mem.sv
      - tests/kcpu_regs_tb.sv

// ==== sim.f ====
src/kcpu_arch_pkg.sv
src/kcpu_ctrl_pkg.sv
src/kcpu_xfer_cnt.sv
src/kcpu_stack_seq.sv
src/kcpu_regs.sv
src/kcpu_regs_top.sv
tests/kcpu_stack_mem.sv
tests/kcpu_regs_tb.sv

// ==== src/kcpu_arch_pkg.sv ====
/*
  architectural types and bit positions of the 6809-style register set
  push/pull mask order matches the postbyte of PSHS/PULS, bit 6 is the other pointer
  exg/tfr codes beyond U read as zero
*/
package kcpu_arch_pkg;

    // plain architectural widths
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [7:0]  psh_mask_t;
    typedef logic [3:0]  tfr_sel_t;

    // push/pull postbyte bits
    localparam int PSH_CC = 0;
    localparam int PSH_A  = 1;
    localparam int PSH_B  = 2;
    localparam int PSH_DP = 3;
    localparam int PSH_X  = 4;
    localparam int PSH_Y  = 5;
    localparam int PSH_SP = 6;
    localparam int PSH_PC = 7;

    // condition code bits
    localparam int CC_C = 0;
    localparam int CC_V = 1;
    localparam int CC_Z = 2;
    localparam int CC_N = 3;
    localparam int CC_I = 4;
    localparam int CC_H = 5;
    localparam int CC_F = 6;
    localparam int CC_E = 7;

    // exg/tfr register codes
    localparam tfr_sel_t TFR_A = 4'd0;
    localparam tfr_sel_t TFR_B = 4'd1;
    localparam tfr_sel_t TFR_X = 4'd2;
    localparam tfr_sel_t TFR_Y = 4'd3;
    localparam tfr_sel_t TFR_S = 4'd4;
    localparam tfr_sel_t TFR_U = 4'd5;

    // indexed addressing register select, anything else reads PC
    localparam logic [2:0] IDX_X = 3'd2;
    localparam logic [2:0] IDX_Y = 3'd3;
    localparam logic [2:0] IDX_U = 3'd5;
    localparam logic [2:0] IDX_S = 3'd6;

endpackage

// ==== src/kcpu_ctrl_pkg.sv ====
/*
  control-side types: sequencer states, per-cycle register update bundle
  and the byte memory port
  upd fields are strobes, valid for one enabled cycle
*/
package kcpu_ctrl_pkg;

    import kcpu_arch_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_PUSH,
        SEQ_PULL,
        SEQ_DONE
    } seq_state_t;

    typedef struct packed {
        word_t      data;
        logic       up_a;
        logic       up_b;
        logic       up_d;
        logic       up_dp;
        logic       up_x;
        logic       up_y;
        logic       up_u;
        logic       up_s;
        logic       up_cc;
        byte_t      alu_cc;
        logic       set_e;
        logic       set_i;
        logic       set_f;
        logic       clr_e;
        logic       dec_b;
        logic       dec_u;
        logic [2:0] idx_rsel;
        logic       idx_post;
        logic       idx_pre;
        logic       idx_wide;
    } reg_upd_t;

    typedef struct packed {
        word_t addr;
        byte_t wdata;
        logic  we;
    } mem_port_t;

endpackage

// ==== src/kcpu_regs.sv ====
/*
  register file: A, B, DP, X, Y, U, S and CC, PC is read only
  A, B and D load from the alu word, DP, X, Y, U and S from upd.data
  later update groups override earlier ones within a cycle
  pulled PC bytes advance the pointer but are not stored here
*/
`timescale 1ns/1ps

module kcpu_regs
    import kcpu_arch_pkg::*, kcpu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  reg_upd_t  upd,
    input  word_t     alu,
    input  word_t     pc,
    input  byte_t     mem_rdata,
    input  psh_mask_t xfer_mask,
    input  logic      xfer_pull,
    input  logic      xfer_push,
    input  logic      use_u,
    input  logic      hilon,
    input  tfr_sel_t  tfr_src,
    input  tfr_sel_t  tfr_dst,
    output byte_t     a,
    output byte_t     b,
    output byte_t     dp,
    output word_t     x,
    output word_t     y,
    output word_t     u,
    output word_t     s,
    output byte_t     cc,
    output word_t     idx_reg,
    output word_t     tfr_src_val,
    output word_t     tfr_dst_val,
    output word_t     psh_addr,
    output byte_t     psh_byte
);

    byte_t      nx_a, nx_b, nx_dp, nx_cc;
    word_t      nx_x, nx_y, nx_u, nx_s;
    word_t      ptr, other;
    word_t      idx_inc, idx_step;
    logic       idx_en;
    logic [2:0] sel;
    psh_mask_t  pul_hit;
    logic       psh_dec, pul_inc;

    function automatic word_t tfr_mux(input tfr_sel_t code, input byte_t ra, input byte_t rb,
                                      input word_t rx, input word_t ry, input word_t rs,
                                      input word_t ru);
        case (code)
            TFR_A:   return {8'hff, ra};
            TFR_B:   return {8'hff, rb};
            TFR_X:   return rx;
            TFR_Y:   return ry;
            TFR_S:   return rs;
            TFR_U:   return ru;
            default: return '0;
        endcase
    endfunction

    assign tfr_src_val = tfr_mux(tfr_src, a, b, x, y, s, u);
    assign tfr_dst_val = tfr_mux(tfr_dst, a, b, x, y, s, u);

    // active stack pointer and the one that bit 6 refers to
    assign ptr      = use_u ? u : s;
    assign other    = use_u ? s : u;
    assign psh_addr = xfer_push ? ptr - 16'd1 : ptr;

    always_comb begin
        case (upd.idx_rsel)
            IDX_X:   idx_reg = x;
            IDX_Y:   idx_reg = y;
            IDX_U:   idx_reg = u;
            IDX_S:   idx_reg = s;
            default: idx_reg = pc;
        endcase
    end

    assign idx_en   = upd.idx_post || upd.idx_pre;
    assign idx_inc  = upd.idx_wide ? 16'd2 : 16'd1;
    assign idx_step = upd.idx_pre ? 16'd0 - idx_inc : idx_inc;

    // push walks down from bit 7, pull walks up from bit 0
    always_comb begin
        sel = 3'd0;
        if (xfer_pull) begin
            for (int i = 7; i >= 0; i--) begin
                if (xfer_mask[i]) sel = 3'(i);
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (xfer_mask[i]) sel = 3'(i);
            end
        end
    end

    always_comb begin
        case (sel)
            PSH_CC:  psh_byte = cc;
            PSH_A:   psh_byte = a;
            PSH_B:   psh_byte = b;
            PSH_DP:  psh_byte = dp;
            PSH_X:   psh_byte = hilon ? x[15:8] : x[7:0];
            PSH_Y:   psh_byte = hilon ? y[15:8] : y[7:0];
            PSH_SP:  psh_byte = hilon ? other[15:8] : other[7:0];
            default: psh_byte = hilon ? pc[15:8] : pc[7:0];
        endcase
    end

    assign psh_dec = xfer_push && (xfer_mask != '0);
    assign pul_hit = xfer_pull ? (xfer_mask & (8'd1 << sel)) : '0;
    assign pul_inc = |pul_hit;

    always_comb begin
        nx_a  = a;
        nx_b  = b;
        nx_dp = dp;
        nx_x  = x;
        nx_y  = y;
        nx_u  = u;
        nx_s  = s;
        nx_cc = cc;
        // plain loads
        if (upd.up_a)  nx_a = alu[7:0];
        if (upd.up_b)  nx_b = alu[7:0];
        if (upd.up_d)  {nx_a, nx_b} = alu;
        if (upd.up_dp) nx_dp = upd.data[7:0];
        if (upd.up_x)  nx_x = upd.data;
        if (upd.up_y)  nx_y = upd.data;
        if (upd.up_u)  nx_u = upd.data;
        if (upd.up_s)  nx_s = upd.data;
        // flags, single bit controls go on top of the alu copy
        if (upd.up_cc) nx_cc = upd.alu_cc;
        if (upd.set_e) nx_cc[CC_E] = 1'b1;
        if (upd.set_i) nx_cc[CC_I] = 1'b1;
        if (upd.set_f) nx_cc[CC_F] = 1'b1;
        if (upd.clr_e) nx_cc[CC_E] = 1'b0;
        if (upd.dec_b) nx_b = b - 8'd1;
        if (upd.dec_u) nx_u = u - 16'd1;
        if (idx_en) begin
            case (upd.idx_rsel)
                IDX_X:   nx_x = x + idx_step;
                IDX_Y:   nx_y = y + idx_step;
                IDX_U:   nx_u = u + idx_step;
                IDX_S:   nx_s = s + idx_step;
                default: ;
            endcase
        end
        // stack traffic
        if (psh_dec) begin
            if (use_u) nx_u = u - 16'd1;
            else       nx_s = s - 16'd1;
        end
        if (pul_inc) begin
            if (use_u) nx_u = u + 16'd1;
            else       nx_s = s + 16'd1;
        end
        if (pul_hit[PSH_CC]) nx_cc = mem_rdata;
        if (pul_hit[PSH_A])  nx_a  = mem_rdata;
        if (pul_hit[PSH_B])  nx_b  = mem_rdata;
        if (pul_hit[PSH_DP]) nx_dp = mem_rdata;
        if (pul_hit[PSH_X]) begin
            if (hilon) nx_x[15:8] = mem_rdata;
            else       nx_x[7:0]  = mem_rdata;
        end
        if (pul_hit[PSH_Y]) begin
            if (hilon) nx_y[15:8] = mem_rdata;
            else       nx_y[7:0]  = mem_rdata;
        end
        if (pul_hit[PSH_SP]) begin
            if (use_u) begin
                if (hilon) nx_s[15:8] = mem_rdata;
                else       nx_s[7:0]  = mem_rdata;
            end else begin
                if (hilon) nx_u[15:8] = mem_rdata;
                else       nx_u[7:0]  = mem_rdata;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= '0;
            b  <= '0;
            dp <= '0;
            x  <= '0;
            y  <= '0;
            u  <= '0;
            s  <= '0;
            cc <= '0;
        end else if (cen) begin
            a  <= nx_a;
            b  <= nx_b;
            dp <= nx_dp;
            x  <= nx_x;
            y  <= nx_y;
            u  <= nx_u;
            s  <= nx_s;
            cc <= nx_cc;
        end
    end

endmodule

// ==== src/kcpu_regs_top.sv ====
/*
  register file with its stack engine
  memory reads are expected to be asynchronous, writes synchronous
  upd must stay idle while busy, transfer updates take precedence
*/
`timescale 1ns/1ps

module kcpu_regs_top
    import kcpu_arch_pkg::*, kcpu_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  reg_upd_t  upd,
    input  word_t     alu,
    input  word_t     pc,
    input  logic      start,
    input  logic      pull,
    input  logic      use_u,
    input  psh_mask_t mask,
    input  tfr_sel_t  tfr_src,
    input  tfr_sel_t  tfr_dst,
    input  byte_t     mem_rdata,
    output mem_port_t mem,
    output logic      busy,
    output logic      done,
    output byte_t     a,
    output byte_t     b,
    output byte_t     dp,
    output word_t     x,
    output word_t     y,
    output word_t     u,
    output word_t     s,
    output byte_t     cc,
    output word_t     idx_reg,
    output word_t     tfr_src_val,
    output word_t     tfr_dst_val
);

    psh_mask_t rem_mask;
    logic      xfer_push, xfer_pull, use_u_q;
    logic      cnt_load, cnt_step, cur_wide;
    logic      hilon, last;
    word_t     psh_addr;
    byte_t     psh_byte;

    kcpu_stack_seq seq0 (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .start     (start),
        .pull      (pull),
        .use_u     (use_u),
        .mask      (mask),
        .last      (last),
        .hilon     (hilon),
        .state     (),
        .rem_mask  (rem_mask),
        .xfer_push (xfer_push),
        .xfer_pull (xfer_pull),
        .use_u_q   (use_u_q),
        .cnt_load  (cnt_load),
        .cnt_step  (cnt_step),
        .cur_wide  (cur_wide),
        .busy      (busy),
        .done      (done)
    );

    kcpu_xfer_cnt cnt0 (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .load     (cnt_load),
        .mask     (mask),
        .step     (cnt_step),
        .cur_wide (cur_wide),
        .hilon    (hilon),
        .last     (last)
    );

    kcpu_regs regs0 (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .upd         (upd),
        .alu         (alu),
        .pc          (pc),
        .mem_rdata   (mem_rdata),
        .xfer_mask   (rem_mask),
        .xfer_pull   (xfer_pull),
        .xfer_push   (xfer_push),
        .use_u       (use_u_q),
        .hilon       (hilon),
        .tfr_src     (tfr_src),
        .tfr_dst     (tfr_dst),
        .a           (a),
        .b           (b),
        .dp          (dp),
        .x           (x),
        .y           (y),
        .u           (u),
        .s           (s),
        .cc          (cc),
        .idx_reg     (idx_reg),
        .tfr_src_val (tfr_src_val),
        .tfr_dst_val (tfr_dst_val),
        .psh_addr    (psh_addr),
        .psh_byte    (psh_byte)
    );

    // write strobe is already qualified by cen
    assign mem.addr  = psh_addr;
    assign mem.wdata = psh_byte;
    assign mem.we    = xfer_push;

endmodule

// ==== src/kcpu_stack_seq.sv ====
/*
  push/pull sequencer, one byte per enabled cycle
  start only counts in SEQ_IDLE, the command is latched there
  while idle cur_wide carries the pull flag so the counter can seed its phase
*/
`timescale 1ns/1ps

module kcpu_stack_seq
    import kcpu_arch_pkg::*, kcpu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       start,
    input  logic       pull,
    input  logic       use_u,
    input  psh_mask_t  mask,
    input  logic       last,
    input  logic       hilon,
    output seq_state_t state,
    output psh_mask_t  rem_mask,
    output logic       xfer_push,
    output logic       xfer_pull,
    output logic       use_u_q,
    output logic       cnt_load,
    output logic       cnt_step,
    output logic       cur_wide,
    output logic       busy,
    output logic       done
);

    logic      pull_q;
    logic      reg_end;
    psh_mask_t clr_bit;

    assign busy      = (state == SEQ_PUSH) || (state == SEQ_PULL);
    assign done      = state == SEQ_DONE;
    assign xfer_push = (state == SEQ_PUSH) && cen;
    assign xfer_pull = (state == SEQ_PULL) && cen;
    assign cnt_load  = (state == SEQ_IDLE) && start;
    assign cnt_step  = busy;

    // pulls end on the wide group, pushes begin with it
    assign cur_wide = (state == SEQ_IDLE) ? pull :
                      pull_q ? (rem_mask[3:0] == '0) : (rem_mask[7:4] != '0);

    // second byte of a word is high on push, low on pull
    assign reg_end = !cur_wide || (hilon ^ pull_q);

    always_comb begin
        clr_bit = '0;
        if (pull_q) begin
            clr_bit = rem_mask & ~(rem_mask - 8'd1);
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (rem_mask[i]) begin
                    clr_bit    = '0;
                    clr_bit[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= SEQ_IDLE;
            rem_mask <= '0;
            pull_q   <= 1'b0;
            use_u_q  <= 1'b0;
        end else if (cen) begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        rem_mask <= mask;
                        pull_q   <= pull;
                        use_u_q  <= use_u;
                        if (mask == '0) state <= SEQ_DONE;
                        else            state <= pull ? SEQ_PULL : SEQ_PUSH;
                    end
                end
                SEQ_PUSH, SEQ_PULL: begin
                    if (reg_end) rem_mask <= rem_mask & ~clr_bit;
                    if (last)    state    <= SEQ_DONE;
                end
                SEQ_DONE: state <= SEQ_IDLE;
                default:  state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

// ==== src/kcpu_xfer_cnt.sv ====
/*
  transfer byte counter, up to 12 bytes for a full mask
  phase is seeded at load from cur_wide (pull flag while idle) and flips
  on every byte of a 16-bit register, so it returns to the seed after each word
*/
`timescale 1ns/1ps

module kcpu_xfer_cnt
    import kcpu_arch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cen,
    input  logic      load,
    input  psh_mask_t mask,
    input  logic      step,
    input  logic      cur_wide,
    output logic      hilon,
    output logic      last
);

    logic [3:0] cnt;
    logic       ph;

    function automatic logic [3:0] byte_count(input psh_mask_t m);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            if (m[i]) n = n + ((i >= PSH_X) ? 4'd2 : 4'd1);
        end
        return n;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            ph  <= 1'b0;
        end else if (cen) begin
            if (load) begin
                cnt <= byte_count(mask);
                ph  <= cur_wide;
            end else if (step) begin
                cnt <= cnt - 4'd1;
                if (cur_wide) ph <= ~ph;
            end
        end
    end

    assign hilon = ph;
    assign last  = cnt == 4'd1;

endmodule

// ==== tests/kcpu_regs_tb.sv ====
/*
  testbench for the register file and its push/pull engine
  the stimulus table is built at time zero from a seeded random stream,
  expected registers follow a model of the register rules kept alongside
  every transfer waits for done with a 100 cycle limit
*/
`timescale 1ns/1ps

module kcpu_regs_tb
    import kcpu_arch_pkg::*, kcpu_ctrl_pkg::*;
;

    typedef struct packed {
        byte_t a;
        byte_t b;
        byte_t dp;
        byte_t cc;
        word_t x;
        word_t y;
        word_t u;
        word_t s;
    } regs_t;

    typedef struct packed {
        reg_upd_t  upd;
        word_t     alu;
        logic      start;
        logic      pull;
        logic      use_u;
        logic      hold;
        psh_mask_t mask;
        tfr_sel_t  tsrc;
        tfr_sel_t  tdst;
        regs_t     exp;
    } step_t;

    logic        clk;
    logic        rst;
    logic        cen;
    reg_upd_t    upd;
    word_t       alu;
    word_t       pc;
    logic        start;
    logic        pull;
    logic        use_u;
    psh_mask_t   mask;
    tfr_sel_t    tfr_src;
    tfr_sel_t    tfr_dst;
    byte_t       mem_rd;
    mem_port_t   mem_bus;
    logic        busy;
    logic        done;
    byte_t       a;
    byte_t       b;
    byte_t       dp;
    byte_t       cc;
    word_t       x;
    word_t       y;
    word_t       u;
    word_t       s;
    word_t       idx_reg;
    word_t       tfr_src_val;
    word_t       tfr_dst_val;

    step_t       tbl[$];
    step_t       ent;
    regs_t       model;
    regs_t       prev;
    word_t       pc_val;
    int          errors;
    int          timeouts;
    int unsigned seed;

    kcpu_regs_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .upd         (upd),
        .alu         (alu),
        .pc          (pc),
        .start       (start),
        .pull        (pull),
        .use_u       (use_u),
        .mask        (mask),
        .tfr_src     (tfr_src),
        .tfr_dst     (tfr_dst),
        .mem_rdata   (mem_rd),
        .mem         (mem_bus),
        .busy        (busy),
        .done        (done),
        .a           (a),
        .b           (b),
        .dp          (dp),
        .x           (x),
        .y           (y),
        .u           (u),
        .s           (s),
        .cc          (cc),
        .idx_reg     (idx_reg),
        .tfr_src_val (tfr_src_val),
        .tfr_dst_val (tfr_dst_val)
    );

    kcpu_stack_mem mem0 (
        .clk   (clk),
        .port  (mem_bus),
        .rdata (mem_rd)
    );

    always #20 clk = ~clk;

    function automatic int xfer_bytes(input psh_mask_t msk);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (msk[i]) n += (i < 4) ? 1 : 2;
        end
        return n;
    endfunction

    function automatic word_t idx_expect(input regs_t r, input logic [2:0] code);
        case (code)
            3'd2:    return r.x;
            3'd3:    return r.y;
            3'd5:    return r.u;
            3'd6:    return r.s;
            default: return pc_val;
        endcase
    endfunction

    // A and B read back with an all-ones upper byte
    function automatic word_t tfr_expect(input regs_t r, input tfr_sel_t code);
        case (code)
            4'd0:    return {8'hff, r.a};
            4'd1:    return {8'hff, r.b};
            4'd2:    return r.x;
            4'd3:    return r.y;
            4'd4:    return r.s;
            4'd5:    return r.u;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic regs_t dut_regs();
        regs_t r;
        r.a  = a;
        r.b  = b;
        r.dp = dp;
        r.cc = cc;
        r.x  = x;
        r.y  = y;
        r.u  = u;
        r.s  = s;
        return r;
    endfunction

    task automatic check_byte(input byte_t got, input byte_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error %0t: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error %0t: %s is %04h, expected %04h", $time, what, got, exp);
        end
    endtask

    task automatic check_mem(input word_t addr, input byte_t exp);
        byte_t got;
        got = mem0.cells[addr];
        if (got !== exp) begin
            errors++;
            $display("error %0t: memory at %04h is %02h, expected %02h", $time, addr, got, exp);
        end
    endtask

    task automatic check_regs(input regs_t exp, input string tag);
        regs_t got;
        got = dut_regs();
        check_byte(got.a, exp.a, {tag, " a"});
        check_byte(got.b, exp.b, {tag, " b"});
        check_byte(got.dp, exp.dp, {tag, " dp"});
        check_byte(got.cc, exp.cc, {tag, " cc"});
        check_word(got.x, exp.x, {tag, " x"});
        check_word(got.y, exp.y, {tag, " y"});
        check_word(got.u, exp.u, {tag, " u"});
        check_word(got.s, exp.s, {tag, " s"});
    endtask

    // big-endian image with CC at the lowest address
    task automatic check_stack(input regs_t r, input psh_mask_t msk, input logic uu);
        word_t ad;
        word_t v[8];
        ad   = (uu ? r.u : r.s) - word_t'(xfer_bytes(msk));
        v[0] = {8'h00, r.cc};
        v[1] = {8'h00, r.a};
        v[2] = {8'h00, r.b};
        v[3] = {8'h00, r.dp};
        v[4] = r.x;
        v[5] = r.y;
        v[6] = uu ? r.s : r.u;
        v[7] = pc_val;
        for (int i = 0; i < 8; i++) begin
            if (msk[i]) begin
                if (i >= 4) begin
                    check_mem(ad, v[i][15:8]);
                    ad++;
                end
                check_mem(ad, v[i][7:0]);
                ad++;
            end
        end
    endtask

    task automatic drive_idle();
        upd     = '0;
        alu     = '0;
        start   = 1'b0;
        pull    = 1'b0;
        use_u   = 1'b0;
        mask    = '0;
        tfr_src = '0;
        tfr_dst = '0;
    endtask

    task automatic add_entry();
        ent.tsrc = tfr_sel_t'($urandom % 8);
        ent.tdst = tfr_sel_t'($urandom % 8);
        ent.exp  = model;
        tbl.push_back(ent);
    endtask

    // one load per register with A, B and D taken from the alu word
    task automatic add_loads();
        for (int k = 0; k < 8; k++) begin
            ent          = '0;
            ent.alu      = word_t'($urandom);
            ent.upd.data = word_t'($urandom);
            case (k)
                0: ent.upd.up_a = 1'b1;
                1: ent.upd.up_b = 1'b1;
                2: ent.upd.up_d = 1'b1;
                3: ent.upd.up_dp = 1'b1;
                4: ent.upd.up_x = 1'b1;
                5: ent.upd.up_y = 1'b1;
                6: ent.upd.up_u = 1'b1;
                default: ent.upd.up_s = 1'b1;
            endcase
            if (k == 0) model.a = ent.alu[7:0];
            if (k == 1) model.b = ent.alu[7:0];
            if (k == 2) {model.a, model.b} = ent.alu;
            if (k == 3) model.dp = ent.upd.data[7:0];
            if (k == 4) model.x = ent.upd.data;
            if (k == 5) model.y = ent.upd.data;
            if (k == 6) model.u = ent.upd.data;
            if (k == 7) model.s = ent.upd.data;
            add_entry();
        end
    endtask

    task automatic add_idx(input logic [2:0] code, input logic pre, input logic wide);
        word_t delta;
        ent               = '0;
        ent.upd.idx_rsel  = code;
        ent.upd.idx_pre   = pre;
        ent.upd.idx_post  = !pre;
        ent.upd.idx_wide  = wide;
        delta = wide ? 16'd2 : 16'd1;
        if (pre) delta = 16'd0 - delta;
        case (code)
            3'd2:    model.x = model.x + delta;
            3'd3:    model.y = model.y + delta;
            3'd5:    model.u = model.u + delta;
            3'd6:    model.s = model.s + delta;
            default: ;
        endcase
        add_entry();
    endtask

    task automatic add_cc();
        logic [31:0] r;
        r              = $urandom;
        ent            = '0;
        ent.upd.alu_cc = byte_t'($urandom);
        ent.upd.up_cc  = r[0];
        ent.upd.set_e  = r[1];
        ent.upd.set_i  = r[2];
        ent.upd.set_f  = r[3];
        ent.upd.clr_e  = r[4];
        if (r[0]) model.cc = ent.upd.alu_cc;
        if (r[1]) model.cc[CC_E] = 1'b1;
        if (r[2]) model.cc[CC_I] = 1'b1;
        if (r[3]) model.cc[CC_F] = 1'b1;
        if (r[4]) model.cc[CC_E] = 1'b0;
        add_entry();
    endtask

    // push then clear all but the pointer and pull back
    task automatic add_xfer(input logic uu, input psh_mask_t msk, input logic hold);
        regs_t saved;
        saved     = model;
        ent       = '0;
        ent.start = 1'b1;
        ent.mask  = msk;
        ent.use_u = uu;
        ent.hold  = hold;
        if (uu) model.u = model.u - word_t'(xfer_bytes(msk));
        else    model.s = model.s - word_t'(xfer_bytes(msk));
        add_entry();
        ent           = '0;
        ent.upd.up_d  = 1'b1;
        ent.upd.up_dp = 1'b1;
        ent.upd.up_x  = 1'b1;
        ent.upd.up_y  = 1'b1;
        ent.upd.up_cc = 1'b1;
        ent.upd.up_s  = uu;
        ent.upd.up_u  = !uu;
        model.a  = '0;
        model.b  = '0;
        model.dp = '0;
        model.cc = '0;
        model.x  = '0;
        model.y  = '0;
        if (uu) model.s = '0;
        else    model.u = '0;
        add_entry();
        ent       = '0;
        ent.start = 1'b1;
        ent.pull  = 1'b1;
        ent.mask  = msk;
        ent.use_u = uu;
        if (msk[PSH_CC]) model.cc = saved.cc;
        if (msk[PSH_A])  model.a  = saved.a;
        if (msk[PSH_B])  model.b  = saved.b;
        if (msk[PSH_DP]) model.dp = saved.dp;
        if (msk[PSH_X])  model.x  = saved.x;
        if (msk[PSH_Y])  model.y  = saved.y;
        if (msk[PSH_SP] && uu)  model.s = saved.s;
        if (msk[PSH_SP] && !uu) model.u = saved.u;
        if (uu) model.u = saved.u;
        else    model.s = saved.s;
        add_entry();
    endtask

    task automatic build_table();
        logic [2:0] codes[5];
        codes = '{3'd2, 3'd3, 3'd5, 3'd6, 3'd0};
        model = '0;
        add_loads();
        for (int k = 0; k < 20; k++) begin
            add_idx(codes[k / 4], k[0], k[1]);
        end
        ent         = '0;
        ent.upd.dec_b = 1'b1;
        ent.upd.dec_u = 1'b1;
        model.b = model.b - 8'd1;
        model.u = model.u - 16'd1;
        add_entry();
        repeat (6) add_cc();
        add_xfer(1'b0, psh_mask_t'($urandom) | 8'h11, 1'b0);
        add_loads();
        add_xfer(1'b1, psh_mask_t'($urandom) | 8'h50, 1'b1);
    endtask

    // nothing may move while the clock enable is low
    task automatic pause_cycles(input int n);
        regs_t held;
        held = dut_regs();
        cen  = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
            check_regs(held, "while cen low");
            check_byte({6'b0, busy, mem_bus.we}, 8'h02, "busy and write strobe while cen low");
        end
        cen = 1'b1;
    endtask

    task automatic run_xfer(input step_t st);
        int cycles;
        int busy_n;
        cycles = 0;
        busy_n = 0;
        do begin
            @(posedge clk);
            cycles++;
            #2;
            drive_idle();
            if (busy) busy_n++;
            // writes only in the push byte cycles
            check_byte({7'b0, mem_bus.we},
                       {7'b0, !st.pull && (cycles <= xfer_bytes(st.mask))},
                       "write strobe");
            if (st.hold && cycles == 2) pause_cycles(4);
        end while (!done && cycles < 100);
        if (!done) begin
            timeouts++;
            $display("transfer with mask %02h did not finish within 100 cycles", st.mask);
        end else begin
            check_word(word_t'(cycles), word_t'(xfer_bytes(st.mask) + 1), "cycles to done");
            check_word(word_t'(busy_n), word_t'(xfer_bytes(st.mask)), "busy cycles");
        end
    endtask

    initial begin
        seed     = 32'hddbf9d28;
        void'($urandom(seed));
        errors   = 0;
        timeouts = 0;
        clk      = 1'b0;
        rst      = 1'b1;
        cen      = 1'b1;
        drive_idle();
        pc_val   = word_t'($urandom);
        pc       = pc_val;
        build_table();
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        check_byte({5'b0, busy, done, mem_bus.we}, 8'h00, "status after reset");
        prev = '0;
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            #2;
            check_regs(prev, $sformatf("before entry %0d", i));
            // done is a single cycle pulse, so both are low again here
            check_byte({6'b0, busy, done}, 8'h00, "busy and done between entries");
            ent     = tbl[i];
            upd     = ent.upd;
            alu     = ent.alu;
            start   = ent.start;
            pull    = ent.pull;
            use_u   = ent.use_u;
            mask    = ent.mask;
            tfr_src = ent.tsrc;
            tfr_dst = ent.tdst;
            #1;
            check_word(idx_reg, idx_expect(prev, ent.upd.idx_rsel), "idx_reg");
            check_word(tfr_src_val, tfr_expect(prev, ent.tsrc), "tfr_src_val");
            check_word(tfr_dst_val, tfr_expect(prev, ent.tdst), "tfr_dst_val");
            if (ent.start) begin
                run_xfer(ent);
                if (!ent.pull) check_stack(prev, ent.mask, ent.use_u);
            end
            prev = ent.exp;
            if (timeouts != 0) break;
        end
        @(posedge clk);
        #2;
        check_regs(prev, "final");
        drive_idle();
        $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/kcpu_stack_mem.sv ====
/*
  64K byte memory for the stack engine, asynchronous read, write on the rising edge
  contents start from a pattern of the full address, not zero
*/
`timescale 1ns/1ps

module kcpu_stack_mem
    import kcpu_arch_pkg::*, kcpu_ctrl_pkg::*;
(
    input  logic      clk,
    input  mem_port_t port,
    output byte_t     rdata
);

    byte_t cells [0:65535];

    // both address bytes fold into the fill value
    initial begin
        for (int i = 0; i < 65536; i++) begin
            cells[i] = byte_t'(i[15:8] ^ i[7:0] ^ 8'ha5);
        end
    end

    assign rdata = cells[port.addr];

    always @(posedge clk) begin
        if (port.we) begin
            cells[port.addr] <= port.wdata;
        end
    end

endmodule
